/* project.f */
+incdir+.
spu_types_pkg.sv
spu_ctrl_pkg.sv
spu_op_if.sv
spu_op_nop.sv
spu_op_mul.sv
spu_op_acc.sv
spu_elem_counter.sv
spu_dot_ctrl.sv
spu_dot_top.sv
spu_dot_props.sv
tb_spu_dot.sv

/* run.sh */
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spu_dot -f project.f -o sim_spu_dot

./obj_dir/sim_spu_dot 2>&1 | tee sim.log || true

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"

/* spu_config.svh */
`ifndef SPU_CONFIG_SVH
`define SPU_CONFIG_SVH

// operand width, signed
`define SPU_DATA_BITS 8

// result width, sum wraps at this size
`define SPU_ACC_BITS 32

// elements per vector
`define SPU_VEC_LEN 8

// multiplier latency in cke cycles
// below 3 the product is combinational and delayed through a nop stage
`define SPU_MUL_LATENCY 3

// arithmetic right shift of each product
`define SPU_DATA_SHIFT 0

`endif

/* spu_ctrl_pkg.sv */
`default_nettype none

package spu_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,   // waiting for start
        RUN,    // taking elements
        DRAIN   // pipeline emptying
    } lane_state_t;

    // flags that follow a beat down the pipeline
    typedef struct packed {
        logic clear;
        logic valid;
        logic last;
    } op_flags_t;

endpackage

`default_nettype wire

/* spu_dot_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module spu_dot_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cke,
    input  logic                    start,
    input  logic                    s_valid,
    input  spu_types_pkg::operand_t s_data0,
    input  spu_types_pkg::operand_t s_data1,
    input  logic                    first,
    input  logic                    last,
    input  logic                    acc_done,
    output logic                    accept,
    output logic                    busy,
    spu_op_if.issue                 op
);

    spu_ctrl_pkg::lane_state_t state;

    assign accept = (state == spu_ctrl_pkg::RUN) && s_valid;
    assign busy   = (state != spu_ctrl_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= spu_ctrl_pkg::IDLE;
            op.clear <= 1'b0;
            op.valid <= 1'b0;
            op.last  <= 1'b0;
        end else if (cke) begin
            op.clear <= 1'b0;
            op.valid <= accept;
            op.last  <= accept && last;
            case (state)
                spu_ctrl_pkg::IDLE: begin
                    if (start && first) begin  // counter must be back at element zero
                        state    <= spu_ctrl_pkg::RUN;
                        op.clear <= 1'b1;
                    end
                end
                spu_ctrl_pkg::RUN: begin
                    if (accept && last) begin
                        state <= spu_ctrl_pkg::DRAIN;
                    end
                end
                spu_ctrl_pkg::DRAIN: begin
                    if (acc_done) begin
                        state <= spu_ctrl_pkg::IDLE;
                    end
                end
                default: state <= spu_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cke && accept) begin
            op.data0 <= s_data0;
            op.data1 <= s_data1;
        end
    end

endmodule

`default_nettype wire

/* spu_dot_props.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spu_config.svh"

module spu_dot_props (
    input logic clk,
    input logic rst,
    input logic cke,
    input logic accept,
    input logic last,
    input logic m_valid,
    input logic busy
);

    // last element in flight with cke high all along
    logic [`SPU_MUL_LATENCY+2:0] pend;

    always_ff @(posedge clk) begin
        if (rst || !cke) begin
            pend <= '0;
        end else begin
            pend <= {pend[`SPU_MUL_LATENCY+1:0], accept && last};
        end
    end

    a_pulse_one_cycle : assert property (
        @(posedge clk) disable iff (rst) (m_valid && cke) |=> !m_valid
    ) else $error("m_valid held longer than one cycle");

    a_valid_while_busy : assert property (
        @(posedge clk) disable iff (rst) m_valid |-> busy
    ) else $error("m_valid outside busy");

    a_idle_after_reset : assert property (
        @(posedge clk) rst |=> (!busy && !m_valid)
    ) else $error("lane not idle after reset");

    a_result_latency : assert property (
        @(posedge clk) disable iff (rst) pend[`SPU_MUL_LATENCY+2] |-> m_valid
    ) else $error("m_valid missing after last element");

endmodule

bind spu_dot_top spu_dot_props u_props (
    .clk     (clk),
    .rst     (rst),
    .cke     (cke),
    .accept  (accept),
    .last    (last),
    .m_valid (m_valid),
    .busy    (busy)
);

`default_nettype wire

/* spu_dot_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spu_config.svh"

module spu_dot_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cke,
    input  logic                    start,
    input  logic                    s_valid,
    input  spu_types_pkg::operand_t s_data0,
    input  spu_types_pkg::operand_t s_data1,
    output spu_types_pkg::acc_t     m_data,
    output logic                    m_valid,
    output logic                    busy
);

    spu_op_if op_bus ();

    logic                    accept;
    logic                    first;
    logic                    last;
    spu_types_pkg::acc_t     product;
    spu_ctrl_pkg::op_flags_t flags_d;

    spu_dot_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cke      (cke),
        .start    (start),
        .s_valid  (s_valid),
        .s_data0  (s_data0),
        .s_data1  (s_data1),
        .first    (first),
        .last     (last),
        .acc_done (m_valid),
        .accept   (accept),
        .busy     (busy),
        .op       (op_bus.issue)
    );

    spu_elem_counter u_counter (
        .clk    (clk),
        .rst    (rst),
        .cke    (cke),
        .accept (accept),
        .clear  (op_bus.clear),
        .first  (first),
        .last   (last)
    );

    spu_op_mul #(
        .LATENCY    (`SPU_MUL_LATENCY),
        .DATA_SHIFT (`SPU_DATA_SHIFT)
    ) u_mul (
        .clk    (clk),
        .rst    (rst),
        .cke    (cke),
        .op     (op_bus.exec),
        .m_data (product)
    );

    // flags ride alongside the product, sampled every cycle
    spu_op_nop #(
        .LATENCY    (`SPU_MUL_LATENCY),
        .DATA_BITS  ($bits(spu_ctrl_pkg::op_flags_t)),
        .CLEAR_DATA ('0)
    ) u_flag_delay (
        .clk    (clk),
        .rst    (rst),
        .cke    (cke),
        .clear  (1'b0),
        .valid  (1'b1),
        .s_data ({op_bus.clear, op_bus.valid, op_bus.last}),
        .m_data (flags_d)
    );

    spu_op_acc u_acc (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .product (product),
        .flags   (flags_d),
        .m_data  (m_data),
        .m_valid (m_valid)
    );

endmodule

`default_nettype wire

/* spu_elem_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spu_config.svh"

module spu_elem_counter (
    input  logic clk,
    input  logic rst,
    input  logic cke,
    input  logic accept,
    input  logic clear,
    output logic first,
    output logic last
);

    localparam int CNT_BITS = (`SPU_VEC_LEN > 1) ? $clog2(`SPU_VEC_LEN) : 1;

    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] base;

    assign base  = clear ? '0 : count;  // clear and element may share a cycle
    assign first = (count == '0);
    assign last  = (count == CNT_BITS'(`SPU_VEC_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (cke) begin
            if (accept) begin
                count <= (base == CNT_BITS'(`SPU_VEC_LEN - 1)) ? '0 : base + 1'b1;
            end else begin
                count <= base;
            end
        end
    end

endmodule

`default_nettype wire

/* spu_op_acc.sv */
`timescale 1ns/10ps
`default_nettype none

module spu_op_acc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cke,
    input  spu_types_pkg::acc_t     product,
    input  spu_ctrl_pkg::op_flags_t flags,
    output spu_types_pkg::acc_t     m_data,
    output logic                    m_valid
);

    spu_types_pkg::acc_t sum;
    logic                done_q;  // final product just added

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q  <= 1'b0;
            m_valid <= 1'b0;
        end else if (cke) begin
            done_q  <= flags.valid && flags.last;
            m_valid <= done_q;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            if (flags.clear) begin
                sum <= '0;
            end else if (flags.valid) begin
                sum <= sum + product;  // wraps modulo 2^width
            end
        end
    end

    // sum is stable until the next clear
    assign m_data = sum;

endmodule

`default_nettype wire

/* spu_op_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface spu_op_if;

    spu_types_pkg::operand_t data0;
    spu_types_pkg::operand_t data1;
    logic                    clear;  // zero the result
    logic                    valid;  // element beat
    logic                    last;   // final element of the vector

    modport issue (
        output data0, data1, clear, valid, last
    );

    modport exec (
        input data0, data1, clear, valid, last
    );

endinterface

`default_nettype wire

/* spu_op_mul.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spu_config.svh"

module spu_op_mul #(
    parameter int LATENCY    = `SPU_MUL_LATENCY,
    parameter int DATA_SHIFT = `SPU_DATA_SHIFT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cke,
    spu_op_if.exec              op,
    output spu_types_pkg::acc_t m_data
);

    if (LATENCY < 3) begin : g_comb
        spu_types_pkg::acc_t prod;

        assign prod = spu_types_pkg::acc_t'(
            (spu_types_pkg::product_t'(op.data0) * spu_types_pkg::product_t'(op.data1))
            >>> DATA_SHIFT);

        spu_op_nop #(
            .LATENCY    (LATENCY),
            .DATA_BITS  ($bits(spu_types_pkg::acc_t)),
            .CLEAR_DATA ('0)
        ) u_delay (
            .clk    (clk),
            .rst    (rst),
            .cke    (cke),
            .clear  (op.clear),
            .valid  (op.valid),
            .s_data (prod),
            .m_data (m_data)
        );
    end else begin : g_pipe
        spu_types_pkg::operand_t st0_data0;
        spu_types_pkg::operand_t st0_data1;
        logic                    st0_clear;
        logic                    st0_valid;
        spu_types_pkg::product_t st1_data;
        logic                    st1_clear;
        logic                    st1_valid;
        spu_types_pkg::acc_t     st2_data;

        always_ff @(posedge clk) begin
            if (rst) begin
                st0_clear <= 1'b0;
                st0_valid <= 1'b0;
                st1_clear <= 1'b0;
                st1_valid <= 1'b0;
            end else if (cke) begin
                st0_clear <= op.clear;
                st0_valid <= op.valid;
                st1_clear <= st0_clear;
                st1_valid <= st0_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (cke) begin
                st0_data0 <= op.data0;
                st0_data1 <= op.data1;
                st1_data  <= (spu_types_pkg::product_t'(st0_data0) *
                              spu_types_pkg::product_t'(st0_data1)) >>> DATA_SHIFT;
                if (st1_clear) begin
                    st2_data <= '0;
                end else if (st1_valid) begin
                    st2_data <= spu_types_pkg::acc_t'(st1_data);  // sign extend
                end
            end
        end

        spu_op_nop #(
            .LATENCY    (LATENCY - 3),
            .DATA_BITS  ($bits(spu_types_pkg::acc_t)),
            .CLEAR_DATA ('0)
        ) u_delay (
            .clk    (clk),
            .rst    (rst),
            .cke    (cke),
            .clear  (1'b0),
            .valid  (1'b1),
            .s_data (st2_data),
            .m_data (m_data)
        );
    end

endmodule

`default_nettype wire

/* spu_op_nop.sv */
`timescale 1ns/10ps
`default_nettype none

module spu_op_nop #(
    parameter int                   LATENCY    = 1,
    parameter int                   DATA_BITS  = 8,
    parameter logic [DATA_BITS-1:0] CLEAR_DATA = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cke,
    input  logic                 clear,
    input  logic                 valid,
    input  logic [DATA_BITS-1:0] s_data,
    output logic [DATA_BITS-1:0] m_data
);

    if (LATENCY == 0) begin : g_wire
        assign m_data = s_data;
    end else begin : g_shift
        logic [DATA_BITS-1:0] stage [LATENCY];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < LATENCY; i++) begin
                    stage[i] <= CLEAR_DATA;
                end
            end else if (cke) begin
                if (clear) begin
                    stage[0] <= CLEAR_DATA;
                end else if (valid) begin
                    stage[0] <= s_data;
                end                               // else hold last input
                for (int i = 1; i < LATENCY; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign m_data = stage[LATENCY-1];
    end

endmodule

`default_nettype wire

/* spu_types_pkg.sv */
`default_nettype none

`include "spu_config.svh"

package spu_types_pkg;

    // one operand element
    typedef logic signed [`SPU_DATA_BITS-1:0] operand_t;

    // full precision product of two operands
    typedef logic signed [2*`SPU_DATA_BITS-1:0] product_t;

    // accumulator word, also the lane result
    typedef logic signed [`SPU_ACC_BITS-1:0] acc_t;

endpackage

`default_nettype wire

/* tb_spu_dot.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spu_config.svh"

module tb_spu_dot;

    localparam int VEC_LEN  = `SPU_VEC_LEN;
    localparam int NUM_VECS = 16;  // over all tests

    localparam spu_types_pkg::operand_t OP_MIN = {1'b1, {(`SPU_DATA_BITS-1){1'b0}}};
    localparam spu_types_pkg::operand_t OP_MAX = {1'b0, {(`SPU_DATA_BITS-1){1'b1}}};

    typedef spu_types_pkg::operand_t vec_t [VEC_LEN];

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cke;
    logic                    start;
    logic                    s_valid;
    spu_types_pkg::operand_t s_data0;
    spu_types_pkg::operand_t s_data1;
    spu_types_pkg::acc_t     m_data;
    logic                    m_valid;
    logic                    busy;

    spu_types_pkg::acc_t exp_q[$];
    string               name_q[$];
    int                  starts_issued = 0;
    int                  results_seen  = 0;

    always #50 clk = ~clk;

    spu_dot_top dut (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .start   (start),
        .s_valid (s_valid),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .m_data  (m_data),
        .m_valid (m_valid),
        .busy    (busy)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_acc(input string name, input spu_types_pkg::acc_t expected,
                             input spu_types_pkg::acc_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                                        name, expected, actual));
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s busy: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    // sum of shifted products, wrapped to the result width
    function automatic spu_types_pkg::acc_t dot_ref(input vec_t a, input vec_t b);
        spu_types_pkg::acc_t sum;
        int                  p;
        sum = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            p   = int'(a[i]) * int'(b[i]);
            p   = p >>> `SPU_DATA_SHIFT;
            sum = sum + spu_types_pkg::acc_t'(p);
        end
        return sum;
    endfunction

    function automatic void fill_random(output vec_t a, output vec_t b);
        for (int i = 0; i < VEC_LEN; i++) begin
            a[i] = spu_types_pkg::operand_t'($urandom);
            b[i] = spu_types_pkg::operand_t'($urandom);
        end
    endfunction

    // called right after a rising edge, returns right after one
    task automatic run_vector(input string name, input vec_t a, input vec_t b,
                              input int gap_pct, input int cke_low_pct, input bit noisy);
        int i;
        bit en;
        bit vld;
        i = 0;
        while (busy) @(posedge clk);
        if (noisy) begin
            repeat ($urandom_range(4, 1)) begin  // dropped while idle
                s_valid <= 1'b1;
                s_data0 <= spu_types_pkg::operand_t'($urandom);
                s_data1 <= spu_types_pkg::operand_t'($urandom);
                @(posedge clk);
            end
        end
        exp_q.push_back(dot_ref(a, b));
        name_q.push_back(name);
        starts_issued++;
        start   <= 1'b1;
        cke     <= 1'b1;
        s_valid <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
        while (i < VEC_LEN) begin
            en  = ($urandom_range(99) >= cke_low_pct);
            vld = ($urandom_range(99) >= gap_pct);
            cke     <= en;
            s_valid <= vld;
            s_data0 <= a[i];
            s_data1 <= b[i];
            if (noisy) start <= 1'($urandom_range(1));  // lane is in RUN
            if (en && vld) i++;
            @(posedge clk);
        end
        cke     <= 1'b1;
        s_valid <= 1'b0;
        start   <= 1'b0;
        if (noisy) begin
            repeat (`SPU_MUL_LATENCY + 2) begin  // lane still draining
                start   <= 1'($urandom_range(1));
                s_valid <= 1'($urandom_range(1));
                @(posedge clk);
            end
            start   <= 1'b0;
            s_valid <= 1'b0;
        end
    endtask

    initial begin : compare
        logic                prev_valid;
        spu_types_pkg::acc_t expected;
        string               name;
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (m_valid && !prev_valid) begin  // held while cke is low
                if (exp_q.size() == 0) begin
                    stop_with_failure("result appeared without a started vector");
                end else begin
                    expected = exp_q.pop_front();
                    name     = name_q.pop_front();
                    check_acc(name, expected, m_data);
                    results_seen++;
                    @(negedge clk);  // acc_done has moved the lane to idle
                    check_busy(name, 1'b0, busy);
                end
            end
            prev_valid = m_valid;
        end
    end

    initial begin : watchdog
        repeat (10 + 200 * NUM_VECS) @(posedge clk);
        stop_with_failure("timeout, the lane stopped producing results");
    end

    initial begin : main
        vec_t a;
        vec_t b;
        void'($urandom(32'h0949_331e));
        rst     = 1'b1;
        cke     = 1'b1;
        start   = 1'b0;
        s_valid = 1'b0;
        s_data0 = '0;
        s_data1 = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        fill_random(a, b);
        run_vector("random_contig", a, b, 0, 0, 1'b0);

        for (int i = 0; i < VEC_LEN; i++) begin
            a[i] = (i % 3 == 2) ? spu_types_pkg::operand_t'(0) : OP_MIN;
            b[i] = (i % 3 == 0) ? OP_MIN : ((i % 3 == 1) ? OP_MAX : spu_types_pkg::operand_t'(0));
        end
        run_vector("extreme_mixed", a, b, 0, 0, 1'b0);
        a = '{default: OP_MIN};
        b = '{default: OP_MIN};
        run_vector("extreme_min_min", a, b, 0, 0, 1'b0);
        b = '{default: OP_MAX};
        run_vector("extreme_min_max", a, b, 0, 0, 1'b0);

        for (int v = 0; v < 4; v++) begin
            fill_random(a, b);
            run_vector($sformatf("gaps_cke_%0d", v), a, b, 40, 30, 1'b0);
        end
        for (int v = 0; v < 4; v++) begin
            fill_random(a, b);
            run_vector($sformatf("back_to_back_%0d", v), a, b, 0, 0, 1'b0);
        end
        for (int v = 0; v < 4; v++) begin
            fill_random(a, b);
            run_vector($sformatf("ignored_inputs_%0d", v), a, b, 20, 0, 1'b1);
        end

        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);  // room for a stray extra result
        if (results_seen != starts_issued) begin
            stop_with_failure($sformatf("%0d results for %0d started vectors",
                                        results_seen, starts_issued));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
